// ==== hdl/obi_sl_pkg.sv ====
// OBI support logic types
package obi_sl_pkg;

  // ------------------------------------------------------------
  // Scalar types
  // ------------------------------------------------------------

  // Program counter source select, as driven by the controller
  typedef logic [2:0] pc_mux_t;

  // Accepted address phase counter, wraps at 256
  typedef logic [7:0] ph_cnt_t;

  // Trap codes of interest
  localparam pc_mux_t PC_TRAP_EXC = 3'b100;
  localparam pc_mux_t PC_TRAP_DBE = 3'b111;

  // ------------------------------------------------------------
  // Bus and control inputs
  // ------------------------------------------------------------

  // One OBI bus as seen at the core port
  typedef struct packed {
    logic req;
    logic gnt;
    // Parity of gnt, correct when inverted
    logic gntpar;
    logic rvalid;
  } obi_bus_t;

  // Attributes of a data request
  typedef struct packed {
    logic is_store;
    logic integrity;
  } data_req_attr_t;

  // Controller outputs used for trap detection
  typedef struct packed {
    logic    pc_set;
    pc_mux_t pc_mux;
  } ctrl_trap_t;

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------

  // Phase status of one bus
  typedef struct packed {
    logic    addr_ph_cont;
    logic    resp_ph_cont;
    ph_cnt_t v_addr_ph_cnt;
  } obi_phase_t;

  // Attributes carried by the request of the current response
  typedef struct packed {
    logic req_was_store;
    logic instr_req_had_integrity;
    logic data_req_had_integrity;
    logic gntpar_error_in_response_instr;
    logic gntpar_error_in_response_data;
  } resp_attr_t;

endpackage

// ==== hdl/obi_phases_monitor.sv ====
// OBI phase monitor
`timescale 1ns/1ps

module obi_phases_monitor (
  input  logic                  in_support_if,
  input  logic                  rst_n_i,
  input  obi_sl_pkg::obi_bus_t  bus_i,
  output obi_sl_pkg::obi_phase_t phase_o
);

  // ------------------------------------------------------------
  // State
  // ------------------------------------------------------------

  // Previous cycle handshake
  logic req_q;
  logic gnt_q;

  // Granted phases still waiting for rvalid
  obi_sl_pkg::ph_cnt_t outstanding_q;

  // Accepted address phases, wrapping
  obi_sl_pkg::ph_cnt_t acc_cnt_q;

  logic addr_acc;

  // Address phase accepted this cycle
  assign addr_acc = bus_i.req && bus_i.gnt;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      req_q         <= 1'b0;
      gnt_q         <= 1'b0;
      outstanding_q <= '0;
      acc_cnt_q     <= '0;
    end else begin
      req_q <= bus_i.req;
      gnt_q <= bus_i.gnt;

      // Grant raises, response lowers, both may happen together
      if (addr_acc && !bus_i.rvalid) begin
        outstanding_q <= outstanding_q + 1'b1;
      end else if (!addr_acc && bus_i.rvalid) begin
        outstanding_q <= outstanding_q - 1'b1;
      end

      if (addr_acc) begin
        acc_cnt_q <= acc_cnt_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------

  // Request still up after an ungranted cycle
  assign phase_o.addr_ph_cont  = bus_i.req && req_q && !gnt_q;
  // Waiting on a response that has not arrived yet
  assign phase_o.resp_ph_cont  = (outstanding_q != '0) && !bus_i.rvalid;
  assign phase_o.v_addr_ph_cnt = acc_cnt_q;

endmodule

// ==== hdl/req_attribute_fifo.sv ====
// Request attribute FIFO
`timescale 1ns/1ps

module req_attribute_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  obi_sl_pkg::obi_bus_t bus_i,
  input  logic                 attr_i,
  output logic                 attr_in_resp_o
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  // Last valid slot index
  localparam ptr_t LAST_SLOT = ptr_t'(FIFO_DEPTH - 1);

  // One attribute bit per outstanding transaction
  logic [FIFO_DEPTH-1:0] attr_mem;

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;

  logic push;
  logic pop;
  logic attr_masked;

  // Push on accepted address phase, pop on response
  assign push = bus_i.req && bus_i.gnt;
  assign pop  = bus_i.rvalid;

  // Attribute is forced low while in reset
  assign attr_masked = attr_i && rst_n_i;

  // Payload only, pointers define validity
  always_ff @(posedge in_support_if) begin
    if (push) begin
      attr_mem[wr_ptr_q] <= attr_masked;
    end
  end

  // Circular pointers with explicit wrap for any depth
  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Output
  // ------------------------------------------------------------

  // Head entry shown only alongside its response
  assign attr_in_resp_o = pop && attr_mem[rd_ptr_q];

endmodule

// ==== hdl/gntpar_error_tracker.sv ====
// Grant parity error tracker
`timescale 1ns/1ps

module gntpar_error_tracker (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  obi_sl_pkg::obi_bus_t bus_i,
  output logic                 gntpar_err_o
);

  // Error seen in an earlier wait cycle of this phase
  logic err_seen_q;

  logic par_bad;

  // Parity is good only when gntpar is the inverse of gnt
  assign par_bad = (bus_i.gnt == bus_i.gntpar);

  // Verdict for the current address phase
  assign gntpar_err_o = bus_i.req && (par_bad || err_seen_q);

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      err_seen_q <= 1'b0;
    end else begin
      // Sticky through wait cycles, cleared once granted or dropped
      if (bus_i.req && !bus_i.gnt) begin
        err_seen_q <= gntpar_err_o;
      end else begin
        err_seen_q <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/exception_req_monitor.sv ====
// Request after exception monitor
`timescale 1ns/1ps

module exception_req_monitor (
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  input  obi_sl_pkg::ctrl_trap_t ctrl_trap_i,
  input  obi_sl_pkg::obi_bus_t   data_bus_i,
  input  logic                   rvfi_valid_i,
  output logic                   req_after_exception_o
);

  logic trap_taken;
  // Trap taken, no retirement since
  logic exc_pending_q;
  // Data grant seen last cycle
  logic data_gnt_q;
  logic new_req;

  // Trap taken in write-back
  assign trap_taken = ctrl_trap_i.pc_set &&
                      (ctrl_trap_i.pc_mux == obi_sl_pkg::PC_TRAP_EXC ||
                       ctrl_trap_i.pc_mux == obi_sl_pkg::PC_TRAP_DBE);

  // Another request right behind a granted one
  assign new_req = data_bus_i.req && data_gnt_q;

  always_ff @(posedge in_support_if) begin
    if (!rst_n_i) begin
      data_gnt_q            <= 1'b0;
      exc_pending_q         <= 1'b0;
      req_after_exception_o <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.gnt;

      if (trap_taken) begin
        exc_pending_q <= 1'b1;
        if (new_req) begin
          req_after_exception_o <= 1'b1;
        end
      end else if (rvfi_valid_i) begin
        // Retirement ends the window
        exc_pending_q         <= 1'b0;
        req_after_exception_o <= 1'b0;
      end else if (exc_pending_q && new_req) begin
        req_after_exception_o <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/obi_support_logic.sv ====
// OBI support logic top
`timescale 1ns/1ps

module obi_support_logic #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       in_support_if,
  input  logic                       rst_n_i,
  input  obi_sl_pkg::obi_bus_t       instr_bus_i,
  input  obi_sl_pkg::obi_bus_t       data_bus_i,
  input  obi_sl_pkg::data_req_attr_t data_attr_i,
  input  logic                       instr_integrity_i,
  input  obi_sl_pkg::ctrl_trap_t     ctrl_trap_i,
  input  logic                       rvfi_valid_i,
  output obi_sl_pkg::obi_phase_t     instr_phase_o,
  output obi_sl_pkg::obi_phase_t     data_phase_o,
  output obi_sl_pkg::resp_attr_t     resp_attr_o,
  output logic                       req_after_exception_o
);

  // ------------------------------------------------------------
  // Phase monitors
  // ------------------------------------------------------------

  obi_phases_monitor instr_phases_mon (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .phase_o       (instr_phase_o)
  );

  obi_phases_monitor data_phases_mon (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .phase_o       (data_phase_o)
  );

  // ------------------------------------------------------------
  // Grant parity errors, one verdict per address phase
  // ------------------------------------------------------------

  logic instr_gntpar_err;
  logic data_gntpar_err;

  gntpar_error_tracker instr_gntpar_trk (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .gntpar_err_o  (instr_gntpar_err)
  );

  gntpar_error_tracker data_gntpar_trk (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .gntpar_err_o  (data_gntpar_err)
  );

  // ------------------------------------------------------------
  // Attribute FIFOs, request to response
  // ------------------------------------------------------------

  logic req_was_store;
  logic instr_had_integrity;
  logic data_had_integrity;
  logic instr_gntpar_in_resp;
  logic data_gntpar_in_resp;

  // Data bus store flag
  req_attribute_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) data_store_fifo (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .bus_i          (data_bus_i),
    .attr_i         (data_attr_i.is_store),
    .attr_in_resp_o (req_was_store)
  );

  // Data bus integrity
  req_attribute_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) data_integrity_fifo (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .bus_i          (data_bus_i),
    .attr_i         (data_attr_i.integrity),
    .attr_in_resp_o (data_had_integrity)
  );

  // Instruction bus integrity
  req_attribute_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) instr_integrity_fifo (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .bus_i          (instr_bus_i),
    .attr_i         (instr_integrity_i),
    .attr_in_resp_o (instr_had_integrity)
  );

  // Grant parity verdicts, sampled at the grant
  req_attribute_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) instr_gntpar_fifo (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .bus_i          (instr_bus_i),
    .attr_i         (instr_gntpar_err),
    .attr_in_resp_o (instr_gntpar_in_resp)
  );

  req_attribute_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) data_gntpar_fifo (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .bus_i          (data_bus_i),
    .attr_i         (data_gntpar_err),
    .attr_in_resp_o (data_gntpar_in_resp)
  );

  assign resp_attr_o.req_was_store                  = req_was_store;
  assign resp_attr_o.instr_req_had_integrity        = instr_had_integrity;
  assign resp_attr_o.data_req_had_integrity         = data_had_integrity;
  assign resp_attr_o.gntpar_error_in_response_instr = instr_gntpar_in_resp;
  assign resp_attr_o.gntpar_error_in_response_data  = data_gntpar_in_resp;

  // ------------------------------------------------------------
  // Data request after trap
  // ------------------------------------------------------------

  exception_req_monitor exc_req_mon (
    .in_support_if         (in_support_if),
    .rst_n_i               (rst_n_i),
    .ctrl_trap_i           (ctrl_trap_i),
    .data_bus_i            (data_bus_i),
    .rvfi_valid_i          (rvfi_valid_i),
    .req_after_exception_o (req_after_exception_o)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

  // Low for the first rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== dv/tb_obi_support_logic.sv ====
// OBI support logic testbench
`timescale 1ns/1ps

module tb_obi_support_logic;

  localparam int FIFO_DEPTH    = 4;
  // Words per vector line, see the column header of the vector file
  localparam int VEC_WORDS     = 12;
  localparam int MAX_VECS      = 64;
  localparam int RESET_TIMEOUT = 40;
  // Reset cycles with bus traffic before the inputs go idle
  localparam int RESET_BUSY    = 4;

  logic                       in_support_if;
  logic                       rst_n_i;
  obi_sl_pkg::obi_bus_t       instr_bus;
  obi_sl_pkg::obi_bus_t       data_bus;
  obi_sl_pkg::data_req_attr_t data_attr;
  logic                       instr_integrity;
  obi_sl_pkg::ctrl_trap_t     ctrl_trap;
  logic                       rvfi_valid;
  obi_sl_pkg::obi_phase_t     instr_phase;
  obi_sl_pkg::obi_phase_t     data_phase;
  obi_sl_pkg::resp_attr_t     resp_attr;
  logic                       req_after_exception;

  // Flat vector image, one byte per column
  logic [7:0] vec_mem [0:VEC_WORDS*MAX_VECS-1];

  tb_clock_gen #(.RESET_CYCLES(10)) clk_gen0 (
    .clk_o   (in_support_if),
    .rst_n_o (rst_n_i)
  );

  obi_support_logic #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
    .in_support_if         (in_support_if),
    .rst_n_i               (rst_n_i),
    .instr_bus_i           (instr_bus),
    .data_bus_i            (data_bus),
    .data_attr_i           (data_attr),
    .instr_integrity_i     (instr_integrity),
    .ctrl_trap_i           (ctrl_trap),
    .rvfi_valid_i          (rvfi_valid),
    .instr_phase_o         (instr_phase),
    .data_phase_o          (data_phase),
    .resp_attr_o           (resp_attr),
    .req_after_exception_o (req_after_exception)
  );

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_phase(input string field, input obi_sl_pkg::obi_phase_t got,
                             input obi_sl_pkg::obi_phase_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t: %s is %h, expected %h",
                                  $time, field, got, exp));
    end
  endtask

  task automatic check_attr(input string field, input obi_sl_pkg::resp_attr_t got,
                            input obi_sl_pkg::resp_attr_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t: %s is %b, expected %b",
                                  $time, field, got, exp));
    end
  endtask

  task automatic check_exc(input string field, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t: %s is %b, expected %b",
                                  $time, field, got, exp));
    end
  endtask

  // Reset holds every output at zero, bus traffic or not
  task automatic check_reset_outputs();
    check_phase("instr_phase_o in reset", instr_phase, '0);
    check_phase("data_phase_o in reset", data_phase, '0);
    check_attr("resp_attr_o in reset", resp_attr, '0);
    check_exc("req_after_exception_o in reset", req_after_exception, 1'b0);
  endtask

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  // Instr waits ungranted, data is granted and answered with all attributes set
  task automatic drive_reset_traffic();
    instr_bus       = obi_sl_pkg::obi_bus_t'(4'ha);
    data_bus        = obi_sl_pkg::obi_bus_t'(4'hd);
    data_attr       = '1;
    instr_integrity = 1'b1;
    ctrl_trap       = obi_sl_pkg::ctrl_trap_t'(4'hc);
    rvfi_valid      = 1'b0;
  endtask

  task automatic drive_idle();
    instr_bus       = '0;
    data_bus        = '0;
    data_attr       = '0;
    instr_integrity = 1'b0;
    ctrl_trap       = '0;
    rvfi_valid      = 1'b0;
  endtask

  // ------------------------------------------------------------
  // Vector handling
  // ------------------------------------------------------------

  task automatic apply_vector(input int idx);
    int base;
    base            = idx * VEC_WORDS;
    instr_bus       = obi_sl_pkg::obi_bus_t'(vec_mem[base][3:0]);
    data_bus        = obi_sl_pkg::obi_bus_t'(vec_mem[base+1][3:0]);
    data_attr       = obi_sl_pkg::data_req_attr_t'(vec_mem[base+2][1:0]);
    instr_integrity = vec_mem[base+3][0];
    ctrl_trap       = obi_sl_pkg::ctrl_trap_t'(vec_mem[base+4][3:0]);
    rvfi_valid      = vec_mem[base+5][0];
  endtask

  task automatic check_vector(input int idx);
    int                     base;
    obi_sl_pkg::obi_phase_t exp_instr;
    obi_sl_pkg::obi_phase_t exp_data;
    obi_sl_pkg::resp_attr_t exp_attr;
    base      = idx * VEC_WORDS;
    // Flag pair then counter byte
    exp_instr = obi_sl_pkg::obi_phase_t'({vec_mem[base+6][1:0], vec_mem[base+7]});
    exp_data  = obi_sl_pkg::obi_phase_t'({vec_mem[base+8][1:0], vec_mem[base+9]});
    exp_attr  = obi_sl_pkg::resp_attr_t'(vec_mem[base+10][4:0]);
    check_phase($sformatf("instr_phase_o in vector %0d", idx), instr_phase, exp_instr);
    check_phase($sformatf("data_phase_o in vector %0d", idx), data_phase, exp_data);
    check_attr($sformatf("resp_attr_o in vector %0d", idx), resp_attr, exp_attr);
    check_exc($sformatf("req_after_exception_o in vector %0d", idx),
              req_after_exception, vec_mem[base+11][0]);
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    int idx;
    int wait_cycles;
    drive_reset_traffic();
    $readmemh("dv/obi_support_tests.txt", vec_mem);

    // Outputs checked through reset and the first cycle after
    wait_cycles = 0;
    while (rst_n_i !== 1'b1) begin
      @(posedge in_support_if);
      @(negedge in_support_if);
      if (wait_cycles == RESET_BUSY) begin
        drive_idle();
      end
      #1.5;
      check_reset_outputs();
      wait_cycles++;
      if (wait_cycles > RESET_TIMEOUT) begin
        stop_with_failure("Timed out waiting for reset to be released");
      end
    end

    // Drive on falling edge, sample half a nanosecond before rising edge
    idx = 0;
    while (vec_mem[idx*VEC_WORDS] != 8'hff) begin
      @(negedge in_support_if);
      apply_vector(idx);
      #1.5;
      check_vector(idx);
      idx++;
      if (idx >= MAX_VECS) begin
        stop_with_failure("Vector file has no end marker within the cycle limit");
      end
    end

    if (idx == 0) begin
      stop_with_failure("Vector file holds no vectors");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// ==== all.f ====
hdl/obi_sl_pkg.sv
hdl/obi_phases_monitor.sv
hdl/req_attribute_fifo.sv
hdl/gntpar_error_tracker.sv
hdl/exception_req_monitor.sv
hdl/obi_support_logic.sv
dv/tb_clock_gen.sv
dv/tb_obi_support_logic.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the OBI support logic testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
sim_out="$(verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_obi_support_logic -Mdir obj_dir -f all.f 2>&1 \
  && ./obj_dir/Vtb_obi_support_logic 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "^TEST OK$" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== dv/obi_support_tests.txt ====
// ibus dbus attr iint trap rvfi   iph icnt dph dcnt rattr exc   (one cycle per line, hex)
// bus={req,gnt,gntpar,rvalid} attr={store,integ} trap={pc_set,pc_mux} ph={addr,resp}
// Instr phase continuation, data store order 1 0 1
2 2 0 0 0 0   0 00 0 00 00 0
a c 2 0 0 0   0 00 0 00 00 0
a c 1 0 0 0   2 00 1 01 00 0
a d 3 0 0 0   2 00 0 02 10 0
c 3 0 1 0 0   2 00 0 03 04 0
c 2 0 0 0 0   1 01 1 03 00 0
2 3 0 0 0 0   1 02 0 03 14 0
3 2 0 0 0 0   0 02 0 03 08 0
2 2 0 0 0 0   1 02 0 03 00 0
3 2 0 0 0 0   0 02 0 03 00 0
2 2 0 0 0 0   0 02 0 03 00 0
// Bad gntpar in an instr wait cycle, clean data phase
8 c 0 0 0 0   0 02 0 03 00 0
c 2 0 0 0 0   2 02 1 04 00 0
3 3 0 0 0 0   0 03 0 04 02 0
2 2 0 0 0 0   0 03 0 04 00 0
// Trap, granted data req, second data req, then retire
2 2 0 0 c 0   0 03 0 04 00 0
2 c 0 0 0 0   0 03 0 04 00 0
2 c 0 0 0 0   0 03 1 05 00 0
2 3 0 0 0 0   0 03 0 06 00 1
2 3 0 0 0 1   0 03 0 06 00 1
2 2 0 0 0 0   0 03 0 06 00 0
// Four outstanding per bus, pc_set without a trap code
c c 1 1 8 0   0 03 0 06 00 0
e c 3 0 0 0   1 04 1 07 00 0
c c 2 1 0 0   1 05 1 08 00 0
c c 0 1 0 0   1 06 1 09 00 0
3 3 0 0 0 0   0 07 0 0a 0c 0
3 3 0 0 0 0   0 07 0 0a 16 0
3 3 0 0 0 0   0 07 0 0a 18 0
3 3 0 0 0 0   0 07 0 0a 08 0
2 2 0 0 0 0   0 07 0 0a 00 0
// End marker
ff ff ff ff ff ff   ff ff ff ff ff ff
